// ==== Makefile ====
TOP = pcie_pio_tb

all: run

compile:
	verilator --binary --assert --top-module $(TOP) -f pcie_pio_top.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: all compile run clean

// ==== pcie_pio_top.f ====
verilog/pcie_tlp_pkg.sv
verilog/pio_regs_pkg.sv
verilog/pcie_rx.sv
verilog/pio_regs.sv
verilog/pcie_tx.sv
verilog/pcie_pio_top.sv
verif/pcie_pio_tb.sv

// ==== verif/pcie_pio_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pcie_pio_tb;
   import pcie_tlp_pkg::*;
   import pio_regs_pkg::*;

   localparam int IRQ_COUNT = 4;
   localparam int NUM_ENTRIES = 18;
   localparam int CPL_TIMEOUT = 200;
   localparam pio_data_t EXT_VALUE = 64'hfeed_0123_4567_beef;
   localparam req_id_t CPL_ID = 16'h0208;

   typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_IRQ, OP_COUNT} op_t;

   typedef struct packed {
      op_t       op;
      pio_addr_t addr;
      pio_data_t data;
      pio_data_t mask;
      logic      bp;
   } entry_t;

   logic                 clock;
   logic                 rst;
   req_id_t              completer_id;
   logic                 rx_tvalid;
   logic                 rx_tlast;
   tlp_beat_t            rx_tdata;
   logic                 tx_tready;
   logic                 tx_tvalid;
   logic                 tx_tlast;
   tlp_beat_t            tx_tdata;
   logic [IRQ_COUNT-1:0] irq_source;
   pio_data_t            ext_status;
   logic                 interrupt_out;
   fifo_reset_t          fifo_reset;

   entry_t               stimulus [NUM_ENTRIES];
   tlp_beat_t            cpl_beat [3];
   logic                 cpl_last [3];
   integer               seed;
   int unsigned          cycle_count;
   int unsigned          read_tlast_cycle;
   int unsigned          prev_tlast;
   pio_data_t            prev_count;
   logic                 have_count;
   logic [7:0]           read_index;
   logic [IRQ_COUNT-1:0] mask_model;
   logic [IRQ_COUNT-1:0] irq_model;
   fifo_reset_t          fifo_model;

   pcie_pio_top #(.IRQ_COUNT(IRQ_COUNT)) DUT
   (
      .clock         (clock),
      .rst           (rst),
      .completer_id  (completer_id),
      .rx_tvalid     (rx_tvalid),
      .rx_tlast      (rx_tlast),
      .rx_tdata      (rx_tdata),
      .tx_tready     (tx_tready),
      .tx_tvalid     (tx_tvalid),
      .tx_tlast      (tx_tlast),
      .tx_tdata      (tx_tdata),
      .irq_source    (irq_source),
      .ext_status    (ext_status),
      .interrupt_out (interrupt_out),
      .fifo_reset    (fifo_reset)
   );

   always #5 clock = ~clock;

   always @(posedge clock)
   begin
      cycle_count <= cycle_count + 1;
   end

   task stop_with_error(input string msg);
      $display("%s", msg);
      $display("SIMULATION FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   task check_value(input string name, input logic [63:0] expected, input logic [63:0] actual);
      assert (actual === expected)
      else
         stop_with_error($sformatf("CHECK FAILED at time %0t: %s expected %h, got %h",
                                   $time, name, expected, actual));
   endtask

   function automatic entry_t make_entry(op_t op, pio_addr_t addr, pio_data_t data,
                                         pio_data_t mask, logic bp);
      entry_t e;
      e.op   = op;
      e.addr = addr;
      e.data = data;
      e.mask = mask;
      e.bp   = bp;
      return e;
   endfunction

   task drive_beat(input tlp_beat_t data, input logic last);
      @(negedge clock);
      rx_tvalid = 1'b1;
      rx_tdata  = data;
      rx_tlast  = last;
      if (last)
         read_tlast_cycle = cycle_count;
   endtask

   task end_packet;
      @(negedge clock);
      rx_tvalid = 1'b0;
      rx_tlast  = 1'b0;
      rx_tdata  = '0;
   endtask

   task write_register(input pio_addr_t addr, input pio_data_t data);
      // MWr32, length 2, all byte enables
      drive_beat({16'h0100, 8'h00, 8'hff, 8'h40, 14'd0, 10'd2}, 1'b0);
      drive_beat({data[31:0], 16'd0, addr, 3'b000}, 1'b0);
      drive_beat({32'd0, data[63:32]}, 1'b1);
      end_packet();
      if (addr == 13'd0)
         mask_model = data[IRQ_COUNT-1:0];
      if (addr == 13'd8)
         fifo_model = data[1:0];
      @(negedge clock);
      check_value("fifo_reset", 64'(fifo_model), 64'(fifo_reset));
   endtask

   // gathers three beats, random tready when bp is set
   task collect_completion(input logic bp);
      int          waited;
      int          n;
      logic        held;
      tlp_beat_t   held_data;
      logic        held_last;
      logic        ready_now;
      logic [31:0] rand_word;
      waited    = 0;
      n         = 0;
      held      = 1'b0;
      held_data = '0;
      held_last = 1'b0;
      while (n < 3)
      begin
         if (waited >= CPL_TIMEOUT)
            stop_with_error("completion did not finish within the timeout");
         else
         begin
            rand_word = $random(seed);
            ready_now = bp ? rand_word[0] : 1'b1;
            tx_tready = ready_now;
            if (held)
            begin
               assert (tx_tvalid)
               else
                  stop_with_error("tx_tvalid dropped before a stalled beat was accepted");
               check_value("tx_tdata while stalled", held_data, tx_tdata);
               check_value("tx_tlast while stalled", 64'(held_last), 64'(tx_tlast));
            end
            if (tx_tvalid)
            begin
               held      = !ready_now;
               held_data = tx_tdata;
               held_last = tx_tlast;
               if (ready_now)
               begin
                  cpl_beat[n] = tx_tdata;
                  cpl_last[n] = tx_tlast;
                  n++;
               end
            end
            @(negedge clock);
            waited++;
         end
      end
      tx_tready = 1'b1;
      check_value("tx_tvalid after tlast", 64'd0, 64'(tx_tvalid));
   endtask

   task read_register(input pio_addr_t addr, input logic bp, output pio_data_t value);
      req_id_t  requester;
      tlp_tag_t tag;
      tlp_dw_t  exp_dw0;
      tlp_dw_t  exp_dw1;
      tlp_dw_t  exp_dw2;
      requester  = {8'h03, read_index};
      tag        = read_index + 8'h10;
      read_index = read_index + 8'd1;
      drive_beat({requester, tag, 8'hff, 8'h00, 14'd0, 10'd2}, 1'b0);
      drive_beat({32'd0, 16'd0, addr, 3'b000}, 1'b1);
      end_packet();
      collect_completion(bp);
      exp_dw0 = {8'h4a, 14'd0, 10'd2};
      exp_dw1 = {CPL_ID, 3'b000, 1'b0, 12'd8};
      // lower address is the byte address of the qword
      exp_dw2 = {requester, tag, 1'b0, addr[3:0], 3'b000};
      check_value("completion beat 0", {exp_dw1, exp_dw0}, cpl_beat[0]);
      check_value("completion dw2", 64'(exp_dw2), 64'(cpl_beat[1][31:0]));
      check_value("tx_tlast beat 0", 64'd0, 64'(cpl_last[0]));
      check_value("tx_tlast beat 1", 64'd0, 64'(cpl_last[1]));
      check_value("tx_tlast beat 2", 64'd1, 64'(cpl_last[2]));
      value = {cpl_beat[2][31:0], cpl_beat[1][63:32]};
   endtask

   task toggle_sources(input pio_data_t data);
      logic [IRQ_COUNT-1:0] next_src;
      int                   expected;
      int                   pulses;
      next_src   = data[IRQ_COUNT-1:0];
      expected   = (|(mask_model & (next_src ^ irq_model))) ? 1 : 0;
      pulses     = 0;
      irq_source = next_src;
      irq_model  = next_src;
      repeat (4)
      begin
         @(negedge clock);
         if (interrupt_out)
            pulses++;
      end
      check_value("interrupt_out pulse cycles", 64'(expected), 64'(pulses));
   endtask

   task check_counter(input pio_data_t value);
      pio_data_t gap;
      if (have_count)
      begin
         gap = 64'(read_tlast_cycle - prev_tlast);
         assert (value > prev_count && (value - prev_count) >= gap)
         else
            stop_with_error($sformatf("CHECK FAILED at time %0t: count expected at least %h, got %h",
                                      $time, prev_count + gap, value));
      end
      prev_count = value;
      prev_tlast = read_tlast_cycle;
      have_count = 1'b1;
   endtask

   initial
   begin
      pio_data_t value;
      clock        = 1'b0;
      rst          = 1'b1;
      completer_id = CPL_ID;
      rx_tvalid    = 1'b0;
      rx_tlast     = 1'b0;
      rx_tdata     = '0;
      tx_tready    = 1'b1;
      irq_source   = '0;
      ext_status   = EXT_VALUE;
      seed         = 32'h65f6325d;
      cycle_count  = 0;
      read_index   = 8'd0;
      have_count   = 1'b0;
      prev_count   = '0;
      prev_tlast   = 0;
      mask_model   = '0;
      irq_model    = '0;
      fifo_model   = 2'b11;

      stimulus[0]  = make_entry(OP_READ,  13'd0,     64'd0, '1, 1'b0);
      stimulus[1]  = make_entry(OP_WRITE, 13'd8,     64'd1, '1, 1'b0);
      stimulus[2]  = make_entry(OP_WRITE, 13'd8,     64'hdead_beef_0000_0002, '1, 1'b0);
      stimulus[3]  = make_entry(OP_READ,  13'd2,     EXT_VALUE, '1, 1'b0);
      stimulus[4]  = make_entry(OP_READ,  13'd5,     64'd0, '1, 1'b0);
      stimulus[5]  = make_entry(OP_READ,  13'h1abc,  64'd0, '1, 1'b1);
      stimulus[6]  = make_entry(OP_WRITE, 13'd0,     64'h5, '1, 1'b0);
      stimulus[7]  = make_entry(OP_IRQ,   13'd0,     64'h1, '1, 1'b0);
      stimulus[8]  = make_entry(OP_IRQ,   13'd0,     64'h0, '1, 1'b0);
      stimulus[9]  = make_entry(OP_IRQ,   13'd0,     64'h2, '1, 1'b0);
      stimulus[10] = make_entry(OP_IRQ,   13'd0,     64'h0, '1, 1'b0);
      // sticky status keeps the masked source too
      stimulus[11] = make_entry(OP_READ,  13'd0,     64'h3, '1, 1'b1);
      stimulus[12] = make_entry(OP_READ,  13'd0,     64'd0, '1, 1'b0);
      stimulus[13] = make_entry(OP_COUNT, 13'd1,     64'd0, '0, 1'b0);
      stimulus[14] = make_entry(OP_COUNT, 13'd1,     64'd0, '0, 1'b1);
      stimulus[15] = make_entry(OP_READ,  13'd2,     EXT_VALUE, '1, 1'b1);
      stimulus[16] = make_entry(OP_WRITE, 13'd8,     64'd0, '1, 1'b0);
      stimulus[17] = make_entry(OP_READ,  13'd9,     64'd0, '1, 1'b1);

      repeat (10) @(negedge clock);
      rst = 1'b0;
      @(negedge clock);
      check_value("interrupt_out", 64'd0, 64'(interrupt_out));
      check_value("tx_tvalid", 64'd0, 64'(tx_tvalid));
      check_value("fifo_reset", 64'h3, 64'(fifo_reset));

      for (int i = 0; i < NUM_ENTRIES; i++)
      begin
         case (stimulus[i].op)
            OP_WRITE:
               write_register(stimulus[i].addr, stimulus[i].data);
            OP_READ:
            begin
               read_register(stimulus[i].addr, stimulus[i].bp, value);
               check_value($sformatf("read data at address %0d", stimulus[i].addr),
                           stimulus[i].data & stimulus[i].mask, value & stimulus[i].mask);
            end
            OP_IRQ:
               toggle_sources(stimulus[i].data);
            default:
            begin
               read_register(stimulus[i].addr, stimulus[i].bp, value);
               check_counter(value);
            end
         endcase
      end

      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/pcie_pio_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pcie_pio_top
#(
   parameter int IRQ_COUNT = 4
)
(
   input  wire                          clock,
   input  wire                          rst,
   input  wire pcie_tlp_pkg::req_id_t   completer_id,
   // receive stream from the core
   input  wire                          rx_tvalid,
   input  wire                          rx_tlast,
   input  wire pcie_tlp_pkg::tlp_beat_t rx_tdata,
   // transmit stream to the core
   input  wire                          tx_tready,
   output logic                         tx_tvalid,
   output logic                         tx_tlast,
   output pcie_tlp_pkg::tlp_beat_t      tx_tdata,
   input  wire [IRQ_COUNT-1:0]          irq_source,
   input  wire pio_regs_pkg::pio_data_t ext_status,
   output logic                         interrupt_out,
   output pio_regs_pkg::fifo_reset_t    fifo_reset
);
   import pcie_tlp_pkg::*;
   import pio_regs_pkg::*;

   logic      write_strobe;
   pio_req_t  write_req;
   logic      read_strobe;
   pio_addr_t read_addr;
   rc_info_t  rc_info;
   logic      rc_done;
   pio_data_t rc_data;

   pcie_rx rx
   (
      .clock        (clock),
      .rst          (rst),
      .rx_tvalid    (rx_tvalid),
      .rx_tlast     (rx_tlast),
      .rx_tdata     (rx_tdata),
      .write_strobe (write_strobe),
      .write_req    (write_req),
      .read_strobe  (read_strobe),
      .read_addr    (read_addr),
      .rc_info      (rc_info)
   );

   pio_regs #(.IRQ_COUNT(IRQ_COUNT)) regs
   (
      .clock         (clock),
      .rst           (rst),
      .write_strobe  (write_strobe),
      .write_req     (write_req),
      .read_strobe   (read_strobe),
      .read_addr     (read_addr),
      .irq_source    (irq_source),
      .ext_status    (ext_status),
      .interrupt_out (interrupt_out),
      .fifo_reset    (fifo_reset),
      .rc_done       (rc_done),
      .rc_data       (rc_data)
   );

   pcie_tx tx
   (
      .clock        (clock),
      .rst          (rst),
      .completer_id (completer_id),
      .rc_done      (rc_done),
      .rc_data      (rc_data),
      .rc_info      (rc_info),
      .tx_tready    (tx_tready),
      .tx_tvalid    (tx_tvalid),
      .tx_tlast     (tx_tlast),
      .tx_tdata     (tx_tdata)
   );

endmodule

`default_nettype wire

// ==== verilog/pcie_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module pcie_rx
(
   input  wire                       clock,
   input  wire                       rst,
   input  wire                       rx_tvalid,
   input  wire                       rx_tlast,
   input  wire pcie_tlp_pkg::tlp_beat_t rx_tdata,
   output logic                      write_strobe,
   output pio_regs_pkg::pio_req_t    write_req,
   output logic                      read_strobe,
   output pio_regs_pkg::pio_addr_t   read_addr,
   output pcie_tlp_pkg::rc_info_t    rc_info
);
   import pcie_tlp_pkg::*;
   import pio_regs_pkg::*;

   typedef enum logic [1:0] {ST_HEADER, ST_ADDRESS, ST_DATA} rx_state_t;

   rx_state_t     state;
   tlp_fmt_type_t fmt_type;
   req_id_t       requester_id;
   tlp_tag_t      tag;
   pio_req_t      req;
   tlp_dw_t       rx_dw_lo;
   tlp_dw_t       rx_dw_hi;

   assign rx_dw_lo = rx_tdata[31:0];
   assign rx_dw_hi = rx_tdata[63:32];

   // beat position and strobes
   always_ff @(posedge clock)
   begin
      if (rst)
      begin
         state        <= ST_HEADER;
         write_strobe <= 1'b0;
         read_strobe  <= 1'b0;
      end
      else
      begin
         write_strobe <= 1'b0;
         read_strobe  <= 1'b0;
         if (rx_tvalid)
         begin
            case (state)
               ST_HEADER:
                  if (!rx_tlast)
                     state <= ST_ADDRESS;
               ST_ADDRESS:
                  if (rx_tlast)
                  begin
                     state       <= ST_HEADER;
                     read_strobe <= (fmt_type == TLP_FMT_TYPE_MRD32);
                  end
                  else
                     state <= ST_DATA;
               // longer payloads stay here until tlast and are dropped
               ST_DATA:
                  if (rx_tlast)
                  begin
                     state        <= ST_HEADER;
                     write_strobe <= (fmt_type == TLP_FMT_TYPE_MWR32);
                  end
               default:
                  state <= ST_HEADER;
            endcase
         end
      end
   end

   // header fields and payload as they pass
   always_ff @(posedge clock)
   begin
      if (rx_tvalid)
      begin
         case (state)
            ST_HEADER:
            begin
               fmt_type     <= rx_dw_lo[31:24];
               requester_id <= rx_dw_hi[31:16];
               tag          <= rx_dw_hi[15:8];
            end
            ST_ADDRESS:
            begin
               req.addr       <= rx_dw_lo[15:3];
               req.data[31:0] <= rx_dw_hi;
            end
            ST_DATA:
               req.data[63:32] <= rx_dw_lo;
            default:
               req.addr <= rx_dw_lo[15:3];
         endcase
         // held for the completion until the next read
         if (state == ST_ADDRESS && rx_tlast && fmt_type == TLP_FMT_TYPE_MRD32)
         begin
            rc_info.requester_id <= requester_id;
            rc_info.tag          <= tag;
            rc_info.lower_addr   <= {rx_dw_lo[6:2], 2'b00};
         end
      end
   end

   assign write_req = req;
   assign read_addr = req.addr;

endmodule

`default_nettype wire

// ==== verilog/pcie_tlp_pkg.sv ====
`default_nettype none

package pcie_tlp_pkg;

   // one header or data double word
   typedef logic [31:0] tlp_dw_t;

   // one beat of the 64-bit core stream, lower DW first
   typedef logic [63:0] tlp_beat_t;

   // bus/device/function
   typedef logic [15:0] req_id_t;

   typedef logic [7:0] tlp_tag_t;
   typedef logic [6:0] lower_addr_t;

   // fmt and type bits of header DW0, bits 31 to 24
   typedef logic [7:0] tlp_fmt_type_t;

   typedef logic [9:0] tlp_length_t;
   typedef logic [2:0] cpl_status_t;
   typedef logic [11:0] byte_count_t;

   // 3-DW header codes
   localparam tlp_fmt_type_t TLP_FMT_TYPE_MWR32 = 8'h40;
   localparam tlp_fmt_type_t TLP_FMT_TYPE_MRD32 = 8'h00;
   localparam tlp_fmt_type_t TLP_FMT_TYPE_CPLD  = 8'h4A;

   // every request and completion moves one qword
   localparam tlp_length_t TLP_LENGTH_QWORD = 10'd2;

   localparam cpl_status_t CPL_STATUS_SC  = 3'b000;
   localparam byte_count_t CPL_BYTE_COUNT = 12'd8;

   // what a completion needs to know about its read request
   typedef struct packed {
      req_id_t     requester_id;
      tlp_tag_t    tag;
      lower_addr_t lower_addr;
   } rc_info_t;

endpackage

`default_nettype wire

// ==== verilog/pcie_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module pcie_tx
(
   input  wire                          clock,
   input  wire                          rst,
   input  wire pcie_tlp_pkg::req_id_t   completer_id,
   input  wire                          rc_done,
   input  wire pio_regs_pkg::pio_data_t rc_data,
   input  wire pcie_tlp_pkg::rc_info_t  rc_info,
   input  wire                          tx_tready,
   output logic                         tx_tvalid,
   output logic                         tx_tlast,
   output pcie_tlp_pkg::tlp_beat_t      tx_tdata
);
   import pcie_tlp_pkg::*;

   typedef enum logic [1:0] {ST_IDLE, ST_BEAT0, ST_BEAT1, ST_BEAT2} tx_state_t;

   tx_state_t state;
   tlp_dw_t   cpl_dw0;
   tlp_dw_t   cpl_dw1;
   tlp_dw_t   cpl_dw2;
   tlp_beat_t beat0;
   tlp_beat_t beat1;
   tlp_beat_t beat2;

   // tc, attr, td and ep all zero
   assign cpl_dw0 = {TLP_FMT_TYPE_CPLD, 14'd0, TLP_LENGTH_QWORD};
   assign cpl_dw1 = {completer_id, CPL_STATUS_SC, 1'b0, CPL_BYTE_COUNT};
   assign cpl_dw2 = {rc_info.requester_id, rc_info.tag, 1'b0, rc_info.lower_addr};

   always_ff @(posedge clock)
   begin
      if (rc_done)
      begin
         beat0 <= {cpl_dw1, cpl_dw0};
         beat1 <= {rc_data[31:0], cpl_dw2};
         beat2 <= {32'd0, rc_data[63:32]};
      end
   end

   // each beat waits for tready
   always_ff @(posedge clock)
   begin
      if (rst)
         state <= ST_IDLE;
      else
      begin
         case (state)
            ST_IDLE:
               if (rc_done)
                  state <= ST_BEAT0;
            ST_BEAT0:
               if (tx_tready)
                  state <= ST_BEAT1;
            ST_BEAT1:
               if (tx_tready)
                  state <= ST_BEAT2;
            ST_BEAT2:
               if (tx_tready)
                  state <= ST_IDLE;
            default:
               state <= ST_IDLE;
         endcase
      end
   end

   assign tx_tvalid = (state != ST_IDLE);
   assign tx_tlast  = (state == ST_BEAT2);

   always_comb
   begin
      case (state)
         ST_BEAT0: tx_tdata = beat0;
         ST_BEAT1: tx_tdata = beat1;
         ST_BEAT2: tx_tdata = beat2;
         default:  tx_tdata = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== verilog/pio_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module pio_regs
#(
   parameter int IRQ_COUNT = 4
)
(
   input  wire                             clock,
   input  wire                             rst,
   input  wire                             write_strobe,
   input  wire pio_regs_pkg::pio_req_t     write_req,
   input  wire                             read_strobe,
   input  wire pio_regs_pkg::pio_addr_t    read_addr,
   input  wire [IRQ_COUNT-1:0]             irq_source,
   input  wire pio_regs_pkg::pio_data_t    ext_status,
   output logic                            interrupt_out,
   output pio_regs_pkg::fifo_reset_t       fifo_reset,
   output logic                            rc_done,
   output pio_regs_pkg::pio_data_t         rc_data
);
   import pio_regs_pkg::*;

   logic [IRQ_COUNT-1:0] irq_mask;
   logic [IRQ_COUNT-1:0] irq_status;
   logic [IRQ_COUNT-1:0] irq_prev;
   pio_data_t            count;
   logic                 status_read;

   assign status_read = read_strobe && (read_addr == REG_IRQ);

   always_ff @(posedge clock)
   begin
      if (rst)
      begin
         irq_mask      <= '0;
         irq_status    <= '0;
         count         <= '0;
         fifo_reset    <= FIFO_RESET_INIT;
         interrupt_out <= 1'b0;
         rc_done       <= 1'b0;
      end
      else
      begin
         count         <= count + 64'd1;
         interrupt_out <= |(irq_mask & (irq_source ^ irq_prev));
         rc_done       <= read_strobe;
         // events in the clearing cycle are lost
         if (status_read)
            irq_status <= '0;
         else
            irq_status <= irq_status | irq_source;
         if (write_strobe)
         begin
            case (write_req.addr)
               REG_IRQ:        irq_mask   <= write_req.data[IRQ_COUNT-1:0];
               REG_FIFO_RESET: fifo_reset <= write_req.data[1:0];
               default:        ;
            endcase
         end
      end
   end

   // previous level for change detection
   always_ff @(posedge clock)
   begin
      irq_prev <= irq_source;
   end

   // read data held until the next read
   always_ff @(posedge clock)
   begin
      if (read_strobe)
      begin
         case (read_addr)
            REG_IRQ:        rc_data <= pio_data_t'(irq_status);
            REG_COUNT:      rc_data <= count;
            REG_EXT_STATUS: rc_data <= ext_status;
            REG_FIFO_RESET: rc_data <= pio_data_t'(fifo_reset);
            default:        rc_data <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== verilog/pio_regs_pkg.sv ====
`default_nettype none

package pio_regs_pkg;

   // qword address, DW2 bits 15 to 3
   typedef logic [12:0] pio_addr_t;

   typedef logic [63:0] pio_data_t;

   typedef logic [1:0] fifo_reset_t;

   typedef struct packed {
      pio_addr_t addr;
      pio_data_t data;
   } pio_req_t;

   // register map
   localparam pio_addr_t REG_IRQ        = 13'd0;
   localparam pio_addr_t REG_COUNT      = 13'd1;
   localparam pio_addr_t REG_EXT_STATUS = 13'd2;
   localparam pio_addr_t REG_FIFO_RESET = 13'd8;

   // both FIFOs held in reset until software releases them
   localparam fifo_reset_t FIFO_RESET_INIT = 2'b11;

endpackage

`default_nettype wire
